/* flist.f */
source/lsu_pkg.sv
source/lsu_fsm.sv
source/lsu_timer.sv
source/lsu_datapath.sv
source/mem_wb.sv
source/wb_top.sv
bench/wb_top_chk.sv
bench/tb_wb_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_wb_top -f flist.f -o sim_wb_top
./obj_dir/sim_wb_top | tee sim.log
if grep -qF "*** PASSED ***" sim.log; then
    echo "Simulation run passed"
else
    echo "Simulation run failed, see sim.log"
    exit 1
fi

/* bench/tb_wb_top.sv */
`timescale 1ns/10ps

module tb_wb_top;

    localparam int N_INSTR         = 72;
    localparam int WATCHDOG_CYCLES = N_INSTR * (int'(lsu_pkg::TIMEOUT_CYCLES) + 20) + 8;
    localparam logic [31:0] SEED   = 32'he0cc_a4f2;

    logic        clk;
    logic        rst_n;
    logic        ex_req_i;
    logic        ex_ack_o;
    logic [63:0] pc_i;
    logic [31:0] inst_i;
    logic [63:0] rs1_val_i;
    logic [63:0] rs2_val_i;
    logic        exu_we_i;
    logic [63:0] exu_wdata_i;
    logic [63:0] csr_mtvec_i;
    logic [63:0] csr_mepc_i;
    logic [63:0] csr_mstatus_i;
    logic [63:0] csr_mcause_i;
    logic        mem_req_o;
    logic        mem_ack_i;
    logic        mem_we_o;
    logic [63:0] mem_addr_o;
    logic [63:0] mem_wdata_o;
    logic [7:0]  mem_wstrb_o;
    logic [63:0] mem_rdata_i;
    logic        commit_valid_o;
    logic [63:0] commit_pc_o;
    logic [31:0] commit_inst_o;
    logic        wb_we_o;
    logic [4:0]  wb_rd_o;
    logic [63:0] wb_wdata_o;
    logic        fault_o;
    logic [63:0] csr_mtvec_o;
    logic [63:0] csr_mepc_o;
    logic [63:0] csr_mstatus_o;
    logic [63:0] csr_mcause_o;

    logic [63:0] model_mem [0:255];  // What the DUT sees
    logic [63:0] ref_mem [0:255];    // Expected contents
    int          checks;
    int          errors;
    int          rnd;

    // Expected record of the transaction in flight
    logic        exp_we;
    logic [63:0] exp_wdata;
    logic        exp_fault;
    logic        exp_mem_op;
    logic        exp_mem_req;
    logic        exp_silent;  // Non-answering region
    logic [7:0]  exp_idx;
    logic [63:0] exp_addr;

    wb_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [63:0] fill_word(input int idx);
        logic [7:0] b;
        b = 8'(idx);
        return {8{b}} ^ 64'h8c3e_f105_7ad2_694b;
    endfunction

    task automatic check_hex(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED %s expected %h got %h", name, expected, actual);
        end
    endtask

    // ****************************************
    // Reference model
    // ****************************************
    task automatic predict(input logic [31:0] inst, input logic [63:0] rs1,
                           input logic [63:0] rs2, input logic we, input logic [63:0] wdata);
        lsu_pkg::inst_u u;
        logic           is_ld;
        logic           is_st;
        logic           misal;
        logic [63:0]    imm;
        logic [63:0]    addr;
        logic [63:0]    val;
        int             size;
        int             off;
        u     = inst;
        is_ld = (u.i.opcode == lsu_pkg::OP_LOAD);
        is_st = (u.s.opcode == lsu_pkg::OP_STORE);
        if (is_st)
            imm = {{52{u.s.imm_hi[6]}}, u.s.imm_hi, u.s.imm_lo};
        else
            imm = {{52{u.i.imm[11]}}, u.i.imm};
        addr        = rs1 + imm;
        size        = 1 << u.i.funct3[1:0];
        off         = int'(addr[2:0]);
        misal       = (off % size) != 0;
        exp_mem_op  = is_ld || is_st;
        exp_mem_req = exp_mem_op && !misal;
        exp_silent  = exp_mem_req && addr[12];
        exp_fault   = exp_mem_op && (misal || addr[12]);
        exp_idx     = addr[10:3];
        exp_addr    = {addr[63:3], 3'b000};
        val         = '0;
        if (!misal) begin
            for (int b = 0; b < size; b++) begin
                val[b*8 +: 8] = ref_mem[exp_idx][(off + b) * 8 +: 8];
            end
        end
        if (!u.i.funct3[2] && size < 8 && val[size*8-1]) begin
            for (int b = size; b < 8; b++) begin
                val[b*8 +: 8] = 8'hff;  // Sign fill
            end
        end
        if (is_st && !exp_fault) begin
            for (int b = 0; b < size; b++) begin
                ref_mem[exp_idx][(off + b) * 8 +: 8] = rs2[b*8 +: 8];
            end
        end
        if (exp_mem_op)
            exp_we = is_ld && !exp_fault && (u.i.rd != 5'd0);
        else
            exp_we = we && (u.i.rd != 5'd0);
        if (!exp_we)
            exp_wdata = '0;
        else if (exp_mem_op)
            exp_wdata = val;
        else
            exp_wdata = wdata;
    endtask

    // One full execute handshake with commit checks
    task automatic run_instr(input logic [31:0] inst, input logic [63:0] rs1,
                             input logic [63:0] rs2, input logic we);
        int          cycles;
        logic        saw_req;
        logic [63:0] wdata;
        wdata = {$urandom, $urandom};
        predict(inst, rs1, rs2, we, wdata);
        @(negedge clk);
        pc_i          = {$urandom, $urandom};
        inst_i        = inst;
        rs1_val_i     = rs1;
        rs2_val_i     = rs2;
        exu_we_i      = we;
        exu_wdata_i   = wdata;
        csr_mtvec_i   = {$urandom, $urandom};
        csr_mepc_i    = {$urandom, $urandom};
        csr_mstatus_i = {$urandom, $urandom};
        csr_mcause_i  = {$urandom, $urandom};
        ex_req_i      = 1'b1;
        cycles        = 0;
        saw_req       = 1'b0;
        do begin
            @(negedge clk);
            cycles++;
            saw_req = saw_req | mem_req_o;
        end while (!ex_ack_o);
        check_hex("commit_valid_o", 64'(1'b1), 64'(commit_valid_o));
        check_hex("commit_pc_o", pc_i, commit_pc_o);
        check_hex("commit_inst_o", 64'(inst), 64'(commit_inst_o));
        check_hex("wb_we_o", 64'(exp_we), 64'(wb_we_o));
        check_hex("wb_rd_o", 64'(inst[11:7]), 64'(wb_rd_o));
        check_hex("wb_wdata_o", exp_wdata, wb_wdata_o);
        check_hex("fault_o", 64'(exp_fault), 64'(fault_o));
        check_hex("csr_mtvec_o", csr_mtvec_i, csr_mtvec_o);
        check_hex("csr_mepc_o", csr_mepc_i, csr_mepc_o);
        check_hex("csr_mstatus_o", csr_mstatus_i, csr_mstatus_o);
        check_hex("csr_mcause_o", csr_mcause_i, csr_mcause_o);
        if (exp_mem_op && !exp_silent)
            check_hex("memory word", ref_mem[exp_idx], model_mem[exp_idx]);
        checks++;
        assert (saw_req == exp_mem_req) else begin
            errors++;
            $display("Memory request seen %0d but expected %0d for instruction %h",
                     saw_req, exp_mem_req, inst);
        end
        checks++;
        assert (exp_mem_op || cycles == 3) else begin
            errors++;
            $display("Non-memory instruction %h took %0d cycles to acknowledge instead of 3",
                     inst, cycles);
        end
        checks++;
        assert (!exp_silent || cycles > int'(lsu_pkg::TIMEOUT_CYCLES)) else begin
            errors++;
            $display("Timeout fault for %h committed after only %0d cycles", inst, cycles);
        end
        ex_req_i = 1'b0;
        do begin
            @(negedge clk);
        end while (ex_ack_o);
    endtask

    // kind 0 aligned, 1 misaligned, 2 non-answering region
    task automatic run_mem(input logic store, input logic [2:0] funct3,
                           input logic [4:0] rd, input int kind);
        lsu_pkg::inst_u u;
        logic [11:0]    imm;
        logic [63:0]    target;
        logic [2:0]     off;
        int             size;
        size = 1 << funct3[1:0];
        off  = 3'($urandom) & ~3'(size - 1);
        if (kind == 1)
            off = off + 3'd1;
        target       = '0;
        target[12]   = (kind == 2);
        target[10:3] = 8'($urandom);
        target[2:0]  = off;
        imm          = 12'($urandom);
        u            = '0;
        if (store) begin
            u.s.imm_hi = imm[11:5];
            u.s.imm_lo = imm[4:0];
            u.s.rs2    = 5'($urandom);
            u.s.rs1    = 5'($urandom);
            u.s.funct3 = funct3;
            u.s.opcode = lsu_pkg::OP_STORE;
        end else begin
            u.i.imm    = imm;
            u.i.rs1    = 5'($urandom);
            u.i.funct3 = funct3;
            u.i.rd     = rd;
            u.i.opcode = lsu_pkg::OP_LOAD;
        end
        run_instr(u, target - {{52{imm[11]}}, imm}, {$urandom, $urandom}, 1'b1);
    endtask

    task automatic run_nonmem(input logic [4:0] rd, input logic we);
        logic [31:0] inst;
        inst       = $urandom;
        inst[6:0]  = 7'b0010011;  // OP-IMM
        inst[11:7] = rd;
        run_instr(inst, {$urandom, $urandom}, {$urandom, $urandom}, we);
    endtask

    task automatic check_reset();
        check_hex("ex_ack_o", '0, 64'(ex_ack_o));
        check_hex("mem_req_o", '0, 64'(mem_req_o));
        check_hex("mem_we_o", '0, 64'(mem_we_o));
        check_hex("mem_addr_o", '0, mem_addr_o);
        check_hex("mem_wdata_o", '0, mem_wdata_o);
        check_hex("mem_wstrb_o", '0, 64'(mem_wstrb_o));
        check_hex("commit_valid_o", '0, 64'(commit_valid_o));
        check_hex("wb_we_o", '0, 64'(wb_we_o));
        check_hex("fault_o", '0, 64'(fault_o));
        check_hex("commit_pc_o", '0, commit_pc_o);
        check_hex("commit_inst_o", '0, 64'(commit_inst_o));
        check_hex("wb_rd_o", '0, 64'(wb_rd_o));
        check_hex("wb_wdata_o", '0, wb_wdata_o);
        check_hex("csr_mtvec_o", '0, csr_mtvec_o);
        check_hex("csr_mepc_o", '0, csr_mepc_o);
        check_hex("csr_mstatus_o", '0, csr_mstatus_o);
        check_hex("csr_mcause_o", '0, csr_mcause_o);
    endtask

    // ****************************************
    // Data memory with random latency
    // ****************************************
    initial begin : memory_model
        int         delay;
        logic [7:0] idx;
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
        forever begin
            @(negedge clk);
            if (mem_req_o) begin
                check_hex("mem_addr_o", exp_addr, mem_addr_o);
                if (!mem_addr_o[12]) begin
                    delay = int'($urandom % 6);
                    repeat (delay) @(negedge clk);
                    idx = mem_addr_o[10:3];
                    if (mem_we_o) begin
                        for (int b = 0; b < 8; b++) begin
                            if (mem_wstrb_o[b])
                                model_mem[idx][b*8 +: 8] = mem_wdata_o[b*8 +: 8];
                        end
                    end else begin
                        mem_rdata_i = model_mem[idx];
                    end
                    mem_ack_i = 1'b1;
                end
                while (mem_req_o) begin
                    @(negedge clk);
                end
                mem_ack_i   = 1'b0;
                mem_rdata_i = {$urandom, $urandom};  // Garbage outside ack
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, a handshake never completed",
                 WATCHDOG_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        rnd    = $urandom(SEED);
        checks = 0;
        errors = 0;
        for (int i = 0; i < 256; i++) begin
            model_mem[i] = fill_word(i);
            ref_mem[i]   = fill_word(i);
        end
        rst_n         = 1'b1;
        ex_req_i      = 1'b0;
        pc_i          = '0;
        inst_i        = '0;
        rs1_val_i     = '0;
        rs2_val_i     = '0;
        exu_we_i      = 1'b0;
        exu_wdata_i   = '0;
        csr_mtvec_i   = '0;
        csr_mepc_i    = '0;
        csr_mstatus_i = '0;
        csr_mcause_i  = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b0;
        check_reset();

        run_nonmem(5'd1, 1'b1);
        run_nonmem(5'd0, 1'b1);   // x0 discards
        run_nonmem(5'd31, 1'b0);
        for (int n = 0; n < 3; n++) begin
            run_nonmem(5'($urandom), 1'b1);
        end

        for (int n = 0; n < 3; n++) begin
            for (int f = 0; f < 4; f++) begin
                run_mem(1'b1, 3'(f), 5'd0, 0);
            end
        end
        for (int n = 0; n < 3; n++) begin
            for (int f = 0; f < 7; f++) begin
                run_mem(1'b0, 3'(f), 5'($urandom % 31 + 1), 0);
            end
        end
        run_mem(1'b0, lsu_pkg::F3_D, 5'd0, 0);

        for (int f = 1; f < 4; f++) begin
            run_mem(1'b0, 3'(f), 5'd7, 1);
            run_mem(1'b1, 3'(f), 5'd0, 1);
        end
        run_mem(1'b0, lsu_pkg::F3_W, 5'd9, 2);
        run_mem(1'b1, lsu_pkg::F3_D, 5'd0, 2);

        // Random mix
        for (int n = 0; n < 24; n++) begin
            rnd = int'($urandom % 10);
            if (rnd < 2)
                run_nonmem(5'($urandom), 1'($urandom));
            else if (rnd < 6)
                run_mem(1'b1, 3'($urandom % 4), 5'd0, ($urandom % 8 == 0) ? 1 : 0);
            else
                run_mem(1'b0, 3'($urandom % 7), 5'($urandom), ($urandom % 8 == 0) ? 1 : 0);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* bench/wb_top_chk.sv */
`timescale 1ns/10ps

module wb_top_chk (
    input logic        clk,
    input logic        rst_n,
    input logic        ex_req_i,
    input logic        ex_ack_i,
    input logic        mem_req_i,
    input logic        mem_ack_i,
    input logic        mem_we_i,
    input logic [63:0] mem_addr_i,
    input logic [63:0] mem_wdata_i,
    input logic [7:0]  mem_wstrb_i,
    input logic        commit_valid_i,
    input logic        timeout_i
);

    // Only the timer may abandon a request
    req_held: assert property (@(posedge clk) disable iff (rst_n)
        mem_req_i && !mem_ack_i && !timeout_i |=> mem_req_i)
        else $error("mem_req_o dropped before mem_ack_i");

    req_stable: assert property (@(posedge clk) disable iff (rst_n)
        mem_req_i && $past(mem_req_i) |-> $stable(mem_we_i) && $stable(mem_addr_i)
            && $stable(mem_wdata_i) && $stable(mem_wstrb_i))
        else $error("Memory outputs changed while mem_req_o was high");

    commit_pulse: assert property (@(posedge clk) disable iff (rst_n)
        commit_valid_i |=> !commit_valid_i)
        else $error("commit_valid_o lasted more than one cycle");

    // Request level at the edge that raised the acknowledge
    ack_rise: assert property (@(posedge clk) disable iff (rst_n)
        $rose(ex_ack_i) |-> $past(ex_req_i))
        else $error("ex_ack_o rose while ex_req_i was low");

endmodule

bind wb_top wb_top_chk u_chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_req_i       (ex_req_i),
    .ex_ack_i       (ex_ack_o),
    .mem_req_i      (mem_req_o),
    .mem_ack_i      (mem_ack_i),
    .mem_we_i       (mem_we_o),
    .mem_addr_i     (mem_addr_o),
    .mem_wdata_i    (mem_wdata_o),
    .mem_wstrb_i    (mem_wstrb_o),
    .commit_valid_i (commit_valid_o),
    .timeout_i      (timeout)
);

/* source/wb_top.sv */
`timescale 1ns/10ps

module wb_top (
    input  logic                     clk,
    input  logic                     rst_n,
    // Execute side
    input  logic                     ex_req_i,
    output logic                     ex_ack_o,
    input  logic [lsu_pkg::XLEN-1:0] pc_i,
    input  logic [31:0]              inst_i,
    input  logic [lsu_pkg::XLEN-1:0] rs1_val_i,
    input  logic [lsu_pkg::XLEN-1:0] rs2_val_i,
    input  logic                     exu_we_i,
    input  logic [lsu_pkg::XLEN-1:0] exu_wdata_i,
    input  logic [lsu_pkg::XLEN-1:0] csr_mtvec_i,
    input  logic [lsu_pkg::XLEN-1:0] csr_mepc_i,
    input  logic [lsu_pkg::XLEN-1:0] csr_mstatus_i,
    input  logic [lsu_pkg::XLEN-1:0] csr_mcause_i,
    // Data memory
    output logic                     mem_req_o,
    input  logic                     mem_ack_i,
    output logic                     mem_we_o,
    output logic [lsu_pkg::XLEN-1:0] mem_addr_o,
    output logic [lsu_pkg::XLEN-1:0] mem_wdata_o,
    output logic [7:0]               mem_wstrb_o,
    input  logic [lsu_pkg::XLEN-1:0] mem_rdata_i,
    // Commit record
    output logic                     commit_valid_o,
    output logic [lsu_pkg::XLEN-1:0] commit_pc_o,
    output logic [31:0]              commit_inst_o,
    output logic                     wb_we_o,
    output logic [4:0]               wb_rd_o,
    output logic [lsu_pkg::XLEN-1:0] wb_wdata_o,
    output logic                     fault_o,
    output logic [lsu_pkg::XLEN-1:0] csr_mtvec_o,
    output logic [lsu_pkg::XLEN-1:0] csr_mepc_o,
    output logic [lsu_pkg::XLEN-1:0] csr_mstatus_o,
    output logic [lsu_pkg::XLEN-1:0] csr_mcause_o
);

    logic                     is_mem;
    logic                     is_store;
    logic                     misaligned;
    logic                     load_latch;
    logic [lsu_pkg::XLEN-1:0] load_data;
    logic                     timer_run;
    logic                     timer_clr;
    logic                     timeout;
    logic                     wb_commit;
    logic                     wb_fault;

    lsu_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_req_i     (ex_req_i),
        .ex_ack_o     (ex_ack_o),
        .is_mem_i     (is_mem),
        .misaligned_i (misaligned),
        .mem_req_o    (mem_req_o),
        .mem_ack_i    (mem_ack_i),
        .load_latch_o (load_latch),
        .timer_run_o  (timer_run),
        .timer_clr_o  (timer_clr),
        .timeout_i    (timeout),
        .wb_commit_o  (wb_commit),
        .wb_fault_o   (wb_fault)
    );

    lsu_timer u_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .run_i     (timer_run),
        .clr_i     (timer_clr),
        .timeout_o (timeout)
    );

    lsu_datapath u_datapath (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_i       (inst_i),
        .rs1_val_i    (rs1_val_i),
        .rs2_val_i    (rs2_val_i),
        .load_latch_i (load_latch),
        .is_mem_o     (is_mem),
        .is_store_o   (is_store),
        .misaligned_o (misaligned),
        .mem_addr_o   (mem_addr_o),
        .mem_we_o     (mem_we_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_wstrb_o  (mem_wstrb_o),
        .mem_rdata_i  (mem_rdata_i),
        .load_data_o  (load_data)
    );

    mem_wb u_mem_wb (
        .clk            (clk),
        .rst_n          (rst_n),
        .commit_i       (wb_commit),
        .fault_i        (wb_fault),
        .is_mem_i       (is_mem),
        .is_store_i     (is_store),
        .exu_we_i       (exu_we_i),
        .pc_i           (pc_i),
        .inst_i         (inst_i),
        .exu_wdata_i    (exu_wdata_i),
        .load_data_i    (load_data),
        .csr_mtvec_i    (csr_mtvec_i),
        .csr_mepc_i     (csr_mepc_i),
        .csr_mstatus_i  (csr_mstatus_i),
        .csr_mcause_i   (csr_mcause_i),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o),
        .commit_inst_o  (commit_inst_o),
        .wb_we_o        (wb_we_o),
        .wb_rd_o        (wb_rd_o),
        .wb_wdata_o     (wb_wdata_o),
        .fault_o        (fault_o),
        .csr_mtvec_o    (csr_mtvec_o),
        .csr_mepc_o     (csr_mepc_o),
        .csr_mstatus_o  (csr_mstatus_o),
        .csr_mcause_o   (csr_mcause_o)
    );

endmodule

/* source/mem_wb.sv */
`timescale 1ns/10ps

module mem_wb (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     commit_i,
    input  logic                     fault_i,
    input  logic                     is_mem_i,
    input  logic                     is_store_i,
    input  logic                     exu_we_i,
    input  logic [lsu_pkg::XLEN-1:0] pc_i,
    input  logic [31:0]              inst_i,
    input  logic [lsu_pkg::XLEN-1:0] exu_wdata_i,
    input  logic [lsu_pkg::XLEN-1:0] load_data_i,
    input  logic [lsu_pkg::XLEN-1:0] csr_mtvec_i,
    input  logic [lsu_pkg::XLEN-1:0] csr_mepc_i,
    input  logic [lsu_pkg::XLEN-1:0] csr_mstatus_i,
    input  logic [lsu_pkg::XLEN-1:0] csr_mcause_i,
    output logic                     commit_valid_o,
    output logic [lsu_pkg::XLEN-1:0] commit_pc_o,
    output logic [31:0]              commit_inst_o,
    output logic                     wb_we_o,
    output logic [4:0]               wb_rd_o,
    output logic [lsu_pkg::XLEN-1:0] wb_wdata_o,
    output logic                     fault_o,
    output logic [lsu_pkg::XLEN-1:0] csr_mtvec_o,
    output logic [lsu_pkg::XLEN-1:0] csr_mepc_o,
    output logic [lsu_pkg::XLEN-1:0] csr_mstatus_o,
    output logic [lsu_pkg::XLEN-1:0] csr_mcause_o
);

    logic [4:0]               rd;
    logic                     we_d;
    logic [lsu_pkg::XLEN-1:0] wdata_d;

    assign rd = inst_i[11:7];

    // Stores and faults never write, x0 is discarded
    always_comb begin
        if (fault_i || rd == 5'd0) begin
            we_d = 1'b0;
        end else if (is_mem_i) begin
            we_d = !is_store_i;
        end else begin
            we_d = exu_we_i;
        end
    end

    assign wdata_d = !we_d ? '0 : (is_mem_i ? load_data_i : exu_wdata_i);

    always_ff @(posedge clk) begin
        if (rst_n) begin
            commit_valid_o <= 1'b0;
            commit_pc_o    <= '0;
            commit_inst_o  <= '0;
            wb_we_o        <= 1'b0;
            wb_rd_o        <= '0;
            wb_wdata_o     <= '0;
            fault_o        <= 1'b0;
            csr_mtvec_o    <= '0;
            csr_mepc_o     <= '0;
            csr_mstatus_o  <= '0;
            csr_mcause_o   <= '0;
        end else begin
            commit_valid_o <= commit_i;  // Single cycle pulse
            if (commit_i) begin
                commit_pc_o   <= pc_i;
                commit_inst_o <= inst_i;
                wb_we_o       <= we_d;
                wb_rd_o       <= rd;
                wb_wdata_o    <= wdata_d;
                fault_o       <= fault_i;
                csr_mtvec_o   <= csr_mtvec_i;
                csr_mepc_o    <= csr_mepc_i;
                csr_mstatus_o <= csr_mstatus_i;
                csr_mcause_o  <= csr_mcause_i;
            end
        end
    end

endmodule

/* source/lsu_datapath.sv */
`timescale 1ns/10ps

module lsu_datapath (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [31:0]              inst_i,
    input  logic [lsu_pkg::XLEN-1:0] rs1_val_i,
    input  logic [lsu_pkg::XLEN-1:0] rs2_val_i,
    input  logic                     load_latch_i,
    output logic                     is_mem_o,
    output logic                     is_store_o,
    output logic                     misaligned_o,
    output logic [lsu_pkg::XLEN-1:0] mem_addr_o,
    output logic                     mem_we_o,
    output logic [lsu_pkg::XLEN-1:0] mem_wdata_o,
    output logic [7:0]               mem_wstrb_o,
    input  logic [lsu_pkg::XLEN-1:0] mem_rdata_i,
    output logic [lsu_pkg::XLEN-1:0] load_data_o
);

    lsu_pkg::inst_u            inst;
    logic                      is_load;
    logic                      is_store;
    logic [2:0]                funct3;
    logic [lsu_pkg::XLEN-1:0]  imm;
    logic [lsu_pkg::XLEN-1:0]  eff_addr;
    logic [2:0]                byte_off;
    logic [7:0]                size_mask;
    logic [lsu_pkg::XLEN-1:0]  rdata_sh;
    logic [lsu_pkg::XLEN-1:0]  load_ext;
    logic [lsu_pkg::XLEN-1:0]  load_q;

    // ****************************************
    // Decode and address
    // ****************************************
    assign inst     = inst_i;
    assign is_load  = (inst.i.opcode == lsu_pkg::OP_LOAD);
    assign is_store = (inst.s.opcode == lsu_pkg::OP_STORE);
    assign funct3   = inst.i.funct3; // Same field position in both formats

    always_comb begin
        if (is_store) begin
            imm = {{52{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
        end else begin
            imm = {{52{inst.i.imm[11]}}, inst.i.imm};
        end
    end

    assign eff_addr = rs1_val_i + imm;
    assign byte_off = eff_addr[2:0];

    // Byte enables for the access size
    always_comb begin
        case (funct3[1:0])
            2'b00:   size_mask = 8'h01;
            2'b01:   size_mask = 8'h03;
            2'b10:   size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end

    always_comb begin
        case (funct3[1:0])
            2'b00:   misaligned_o = 1'b0;
            2'b01:   misaligned_o = is_load | is_store ? eff_addr[0] : 1'b0;
            2'b10:   misaligned_o = is_load | is_store ? |eff_addr[1:0] : 1'b0;
            default: misaligned_o = is_load | is_store ? |eff_addr[2:0] : 1'b0;
        endcase
    end

    assign is_mem_o    = is_load | is_store;
    assign is_store_o  = is_store;
    assign mem_we_o    = is_store;
    assign mem_addr_o  = {eff_addr[lsu_pkg::XLEN-1:3], 3'b000};  // Doubleword aligned
    assign mem_wdata_o = rs2_val_i << {byte_off, 3'b000};
    assign mem_wstrb_o = is_store ? (size_mask << byte_off) : 8'h00;

    // ****************************************
    // Load extraction
    // ****************************************
    assign rdata_sh = mem_rdata_i >> {byte_off, 3'b000};

    always_comb begin
        case (funct3)
            lsu_pkg::F3_B:  load_ext = {{56{rdata_sh[7]}}, rdata_sh[7:0]};
            lsu_pkg::F3_BU: load_ext = {56'b0, rdata_sh[7:0]};
            lsu_pkg::F3_H:  load_ext = {{48{rdata_sh[15]}}, rdata_sh[15:0]};
            lsu_pkg::F3_HU: load_ext = {48'b0, rdata_sh[15:0]};
            lsu_pkg::F3_W:  load_ext = {{32{rdata_sh[31]}}, rdata_sh[31:0]};
            lsu_pkg::F3_WU: load_ext = {32'b0, rdata_sh[31:0]};
            default:        load_ext = rdata_sh;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            load_q <= '0;
        end else if (load_latch_i) begin
            load_q <= load_ext;  // Captured on the ack edge
        end
    end

    assign load_data_o = load_q;

endmodule

/* source/lsu_timer.sv */
`timescale 1ns/10ps

module lsu_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic run_i,
    input  logic clr_i,
    output logic timeout_o
);

    logic [lsu_pkg::TIMER_W-1:0] cnt_q;

    // Saturates at the limit
    always_ff @(posedge clk) begin
        if (rst_n) begin
            cnt_q <= '0;
        end else if (clr_i) begin
            cnt_q <= '0;
        end else if (run_i && !timeout_o) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign timeout_o = (cnt_q == lsu_pkg::TIMEOUT_CYCLES);

endmodule

/* source/lsu_fsm.sv */
`timescale 1ns/10ps

module lsu_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic ex_req_i,
    output logic ex_ack_o,
    input  logic is_mem_i,
    input  logic misaligned_i,
    output logic mem_req_o,
    input  logic mem_ack_i,
    output logic load_latch_o,
    output logic timer_run_o,
    output logic timer_clr_o,
    input  logic timeout_i,
    output logic wb_commit_o,
    output logic wb_fault_o
);

    lsu_pkg::lsu_state_e state_q;
    lsu_pkg::lsu_state_e state_d;
    logic req_q;    // Execute request, sampled once
    logic fault_q;
    logic fault_d;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            state_q <= lsu_pkg::IDLE;
            req_q   <= 1'b0;
            fault_q <= 1'b0;
        end else begin
            state_q <= state_d;
            req_q   <= ex_req_i;
            fault_q <= fault_d;
        end
    end

    // ****************************************
    // Next state
    // ****************************************
    always_comb begin
        state_d = state_q;
        fault_d = fault_q;
        case (state_q)
            lsu_pkg::IDLE: begin
                fault_d = 1'b0;
                if (req_q) begin
                    if (is_mem_i && misaligned_i) begin
                        state_d = lsu_pkg::COMMIT; // No bus cycle at all
                        fault_d = 1'b1;
                    end else if (is_mem_i) begin
                        state_d = lsu_pkg::MEM_REQ;
                    end else begin
                        state_d = lsu_pkg::COMMIT;
                    end
                end
            end
            lsu_pkg::MEM_REQ: begin
                if (mem_ack_i) begin
                    state_d = lsu_pkg::MEM_DROP;
                end else if (timeout_i) begin
                    state_d = lsu_pkg::MEM_DROP; // Abandon, still wait for ack low
                    fault_d = 1'b1;
                end
            end
            lsu_pkg::MEM_DROP: begin
                if (!mem_ack_i) begin
                    state_d = lsu_pkg::COMMIT;
                end
            end
            lsu_pkg::COMMIT: begin
                state_d = lsu_pkg::ACK;
            end
            lsu_pkg::ACK: begin
                if (!req_q) begin
                    state_d = lsu_pkg::IDLE; // Driver released request
                end
            end
            default: begin
                state_d = lsu_pkg::IDLE;
            end
        endcase
    end

    // ****************************************
    // Outputs
    // ****************************************
    assign ex_ack_o     = (state_q == lsu_pkg::ACK);
    assign mem_req_o    = (state_q == lsu_pkg::MEM_REQ);
    assign load_latch_o = (state_q == lsu_pkg::MEM_REQ) && mem_ack_i;
    assign timer_run_o  = (state_q == lsu_pkg::MEM_REQ);
    assign timer_clr_o  = (state_q == lsu_pkg::IDLE);
    assign wb_commit_o  = (state_q == lsu_pkg::COMMIT);
    assign wb_fault_o   = fault_q;

endmodule

/* source/lsu_pkg.sv */
package lsu_pkg;

    // ****************************************
    // Widths and decode constants
    // ****************************************
    localparam int XLEN = 64;

    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    // Access size in funct3[1:0], unsigned flag in funct3[2]
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_D  = 3'b011;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;
    localparam logic [2:0] F3_WU = 3'b110;

    localparam int TIMER_W = 5;
    localparam logic [TIMER_W-1:0] TIMEOUT_CYCLES = 5'd16; // Memory ack wait limit

    typedef enum logic [2:0] {
        IDLE,
        MEM_REQ,
        MEM_DROP,
        COMMIT,
        ACK
    } lsu_state_e;

    // ****************************************
    // Instruction word views
    // ****************************************
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } itype_s;

    typedef struct packed {
        logic [6:0] imm_hi;  // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;  // imm[4:0]
        logic [6:0] opcode;
    } stype_s;

    typedef union packed {
        itype_s i;  // Loads
        stype_s s;  // Stores
    } inst_u;

endpackage
